/* rtl/dtePkg.sv */
`default_nettype none

package dtePkg;

  localparam int axiAddrWidth = 5;

  typedef enum logic [2:0] {
    dteMisc        = 3'd0,
    dteWrite       = 3'd1,
    dteDiagFunc    = 3'd2,
    dteRead        = 3'd3,
    dteReleaseData = 3'd4
  } tReqType;

  // Misc request functions
  localparam logic [6:0] dfClrCrobar = 7'o01;
  localparam logic [6:0] dfGetAprId  = 7'o02;

  // Functions decoded by the diagnostic target
  localparam logic [6:0] dsLoadScratch       = 7'o20;
  localparam logic [6:0] dsReadScratch       = 7'o21;
  localparam logic [6:0] dsComplementScratch = 7'o22;
  localparam logic [6:0] dsReadCount         = 7'o23;

  typedef struct packed {
    logic [0:17]  lh;
    logic [18:35] rh;
  } tWord36;

  // Microcode version and hardware options reported by Misc requests
  localparam logic [0:5]   ucodeMajorVal = 6'o02;
  localparam logic [6:8]   ucodeMinorVal = 3'o1;
  localparam logic [0:8]   ucodeEditVal  = 9'o442;
  localparam logic [18:35] hwOptionsVal  = 18'o400021;

  typedef struct packed {
    logic [0:5]   ucodeMajor;
    logic [6:8]   ucodeMinor;
    logic [0:8]   ucodeEdit;
    logic [18:35] hwOptions;
  } tAprIdFields;

  typedef union packed {
    tWord36      raw;
    tAprIdFields fields;
  } tAprId;

  typedef struct packed {
    tReqType    reqType;
    logic [6:0] diagFunc;
    tWord36     data;
  } tDteReq;

  typedef struct packed {
    logic [6:0] ds;
    logic       diagStrobe;
    logic       driving;     // Sequencer owns the data lines
    tWord36     data;
  } tEbus;

  typedef struct packed {
    logic busy;
    logic crobar;
  } tDteStatus;

  // Command word holds the type in bits 10:8 and the function in 6:0
  localparam logic [axiAddrWidth-1:0] regCmd     = 5'h00;
  localparam logic [axiAddrWidth-1:0] regDataLh  = 5'h04;
  localparam logic [axiAddrWidth-1:0] regDataRh  = 5'h08;
  localparam logic [axiAddrWidth-1:0] regStatus  = 5'h0C;
  localparam logic [axiAddrWidth-1:0] regReplyLh = 5'h10;
  localparam logic [axiAddrWidth-1:0] regReplyRh = 5'h14;

endpackage

`default_nettype wire

/* rtl/dteAxiRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module dteAxiRegs (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dtePkg::axiAddrWidth-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [31:0]                     wdata,
  input  logic [3:0]                      wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [dtePkg::axiAddrWidth-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [31:0]                     rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready,
  output dtePkg::tDteReq                  req,
  output logic                            reqValid,
  input  logic                            reqReady,
  input  dtePkg::tWord36                  reply,
  input  logic                            replyValid,
  input  dtePkg::tDteStatus               status
);

  logic           wrFire;
  logic           rdFire;
  logic           busy;
  logic [31:0]    readMux;
  dtePkg::tWord36 dataWord;
  dtePkg::tWord36 replyWord;

  function automatic logic [17:0] mergeHalf(input logic [17:0] old,
                                            input logic [31:0] data,
                                            input logic [3:0]  strb);
    logic [31:0] merged;
    merged = {14'b0, old};
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = data[8*i +: 8];
      end
    end
    return merged[17:0];
  endfunction

  assign busy    = reqValid || status.busy;  // Covers the gap before transfer
  assign wrFire  = awvalid && wvalid && !bvalid;
  assign awready = wrFire;
  assign wready  = wrFire;
  assign bresp   = 2'b00;
  assign rdFire  = arvalid && !rvalid;
  assign arready = !rvalid;
  assign rresp   = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      reqValid <= 1'b0;
      bvalid   <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      if (reqValid && reqReady) reqValid <= 1'b0;
      if (wrFire) begin
        bvalid <= 1'b1;
        if (awaddr == dtePkg::regCmd && !busy) reqValid <= 1'b1;  // Busy drops it
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rdFire) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wrFire) begin
      case (awaddr)
        dtePkg::regCmd: begin
          if (!busy) begin
            req.reqType  <= dtePkg::tReqType'(wdata[10:8]);
            req.diagFunc <= wdata[6:0];
            req.data     <= dataWord;
          end
        end
        dtePkg::regDataLh: dataWord.lh <= mergeHalf(dataWord.lh, wdata, wstrb);
        dtePkg::regDataRh: dataWord.rh <= mergeHalf(dataWord.rh, wdata, wstrb);
        default: ;
      endcase
    end
    if (replyValid) replyWord <= reply;
    if (rdFire) rdata <= readMux;
  end

  always_comb begin
    readMux = '0;
    case (araddr)
      dtePkg::regCmd:     readMux = {21'b0, req.reqType, 1'b0, req.diagFunc};
      dtePkg::regDataLh:  readMux = {14'b0, dataWord.lh};
      dtePkg::regDataRh:  readMux = {14'b0, dataWord.rh};
      dtePkg::regStatus:  readMux = {30'b0, status.crobar, busy};
      dtePkg::regReplyLh: readMux = {14'b0, replyWord.lh};
      dtePkg::regReplyRh: readMux = {14'b0, replyWord.rh};
      default: ;
    endcase
  end

  // Responses stay put until the host takes them
  assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid);
  assert property (@(posedge clk) disable iff (rst)
                   rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

/* rtl/dte.sv */
`timescale 1ns/1ns
`default_nettype none

module dte (
  input  logic              clk,
  input  logic              rst,
  input  dtePkg::tDteReq    req,
  input  logic              reqValid,
  output logic              reqReady,
  output dtePkg::tEbus      ebus,
  input  dtePkg::tWord36    targetData,
  output dtePkg::tWord36    reply,
  output logic              replyValid,
  output dtePkg::tDteStatus status,
  output logic              crobar
);

  typedef enum logic [1:0] {
    stIdle,
    stExec,
    stSample
  } tState;

  tState           state;
  dtePkg::tReqType reqTypeQ;
  logic            busyQ;
  logic            reqFire;
  logic            strobing;
  logic [6:0]      dsQ;
  logic            strobeQ;
  logic            drivingQ;
  dtePkg::tWord36  dataQ;
  dtePkg::tAprId   aprId;

  assign reqReady = (state == stIdle) && !busyQ;
  assign reqFire  = reqValid && reqReady;
  assign strobing = reqFire && (req.reqType == dtePkg::dteWrite ||
                                req.reqType == dtePkg::dteDiagFunc);

  always_comb begin
    aprId.fields.ucodeMajor = dtePkg::ucodeMajorVal;
    aprId.fields.ucodeMinor = dtePkg::ucodeMinorVal;
    aprId.fields.ucodeEdit  = dtePkg::ucodeEditVal;
    aprId.fields.hwOptions  = dtePkg::hwOptionsVal;
  end

  // A held strobe dips for the transfer cycle so the target sees a new edge
  assign ebus.ds         = dsQ;
  assign ebus.diagStrobe = strobeQ && !strobing;
  assign ebus.driving    = drivingQ && !strobing;
  assign ebus.data       = dataQ;

  assign status.busy   = busyQ;
  assign status.crobar = crobar;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= stIdle;
      busyQ      <= 1'b0;
      replyValid <= 1'b0;
      strobeQ    <= 1'b0;
      drivingQ   <= 1'b0;
      crobar     <= 1'b1;                   // Crowbar up out of reset
    end else begin
      replyValid <= (state == stSample);
      if (replyValid) busyQ <= 1'b0;
      case (state)
        stIdle: begin
          if (reqFire) begin
            state <= stExec;
            busyQ <= 1'b1;
            case (req.reqType)
              dtePkg::dteMisc: begin
                case (req.diagFunc)
                  dtePkg::dfClrCrobar: crobar <= 1'b0;
                  dtePkg::dfGetAprId: ;     // Reply only
                  default: ;
                endcase
              end
              dtePkg::dteWrite: begin
                strobeQ  <= 1'b1;
                drivingQ <= 1'b1;
              end
              dtePkg::dteDiagFunc: strobeQ <= 1'b1;
              dtePkg::dteReleaseData: begin
                strobeQ  <= 1'b0;
                drivingQ <= 1'b0;
              end
              default: ;                    // Read leaves the bus alone
            endcase
          end
        end
        stExec:   state <= stSample;       // Target latches its selection
        stSample: state <= stIdle;
        default:  state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reqFire) begin
      reqTypeQ <= req.reqType;
      if (strobing) dsQ <= req.diagFunc;
      if (req.reqType == dtePkg::dteWrite) dataQ <= req.data;
      else if (req.reqType == dtePkg::dteReleaseData) dataQ <= '0;
    end
    if (state == stSample) begin
      reply <= (reqTypeQ == dtePkg::dteMisc) ? aprId.raw : targetData;
    end
  end

  assert property (@(posedge clk) disable iff (rst) replyValid |-> status.busy);
  assert property (@(posedge clk) disable iff (rst) $rose(ebus.driving) |-> ebus.diagStrobe);

endmodule

`default_nettype wire

/* rtl/ebusDiagTarget.sv */
`timescale 1ns/1ns
`default_nettype none

module ebusDiagTarget (
  input  logic           clk,
  input  logic           rst,
  input  dtePkg::tEbus   ebus,
  output dtePkg::tWord36 targetData
);

  logic           strobePrev;
  logic           strobeEdge;
  logic [6:0]     sel;
  logic [35:0]    count;
  dtePkg::tWord36 scratch;
  dtePkg::tWord36 selWord;

  assign strobeEdge = ebus.diagStrobe && !strobePrev;

  always_ff @(posedge clk) begin
    if (rst) begin
      strobePrev <= 1'b0;
      sel        <= '0;
      count      <= '0;
      scratch    <= '0;
    end else begin
      strobePrev <= ebus.diagStrobe;
      if (strobeEdge) begin
        sel   <= ebus.ds;                  // Selection follows the last function
        count <= count + 36'd1;
        case (ebus.ds)
          dtePkg::dsLoadScratch:       scratch <= ebus.data;
          dtePkg::dsComplementScratch: scratch <= dtePkg::tWord36'(~scratch);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (sel)
      dtePkg::dsReadScratch,
      dtePkg::dsLoadScratch: selWord = scratch;
      dtePkg::dsReadCount:   selWord = count;
      default:               selWord = '0;
    endcase
  end

  // Sequencer data wins while it drives the bus
  assign targetData = ebus.driving ? ebus.data : selWord;

endmodule

`default_nettype wire

/* rtl/dteSubsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module dteSubsystem (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dtePkg::axiAddrWidth-1:0] awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [31:0]                     wdata,
  input  logic [3:0]                      wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  output logic [1:0]                      bresp,
  output logic                            bvalid,
  input  logic                            bready,
  input  logic [dtePkg::axiAddrWidth-1:0] araddr,
  input  logic                            arvalid,
  output logic                            arready,
  output logic [31:0]                     rdata,
  output logic [1:0]                      rresp,
  output logic                            rvalid,
  input  logic                            rready,
  output logic                            crobar
);

  dtePkg::tDteReq    req;
  logic              reqValid;
  logic              reqReady;
  dtePkg::tWord36    reply;
  logic              replyValid;
  dtePkg::tDteStatus status;
  dtePkg::tEbus      ebus;
  dtePkg::tWord36    targetData;

  dteAxiRegs regs (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .req(req), .reqValid(reqValid), .reqReady(reqReady),
    .reply(reply), .replyValid(replyValid), .status(status)
  );

  dte sequencer (
    .clk(clk), .rst(rst),
    .req(req), .reqValid(reqValid), .reqReady(reqReady),
    .ebus(ebus), .targetData(targetData),
    .reply(reply), .replyValid(replyValid),
    .status(status), .crobar(crobar)
  );

  ebusDiagTarget target (
    .clk(clk), .rst(rst),
    .ebus(ebus), .targetData(targetData)
  );

endmodule

`default_nettype wire

/* dv/dteTb.sv */
`timescale 1ns/1ns
`default_nettype none

module dteTb;

  localparam int    clkPeriod   = 40;
  localparam int    resetCycles = 8;
  localparam int    pollLimit   = 50;
  localparam int    lineCycles  = 400;
  localparam string goldenPath  = "dv/dteGolden.txt";

  typedef struct packed {
    dtePkg::tReqType reqType;
    logic [6:0]      func;
    dtePkg::tWord36  data;
    dtePkg::tWord36  expReply;
    logic            expCrobar;
  } tGoldenLine;

  logic                            clk;
  logic                            rst;
  logic [dtePkg::axiAddrWidth-1:0] awaddr;
  logic                            awvalid;
  logic                            awready;
  logic [31:0]                     wdata;
  logic [3:0]                      wstrb;
  logic                            wvalid;
  logic                            wready;
  logic [1:0]                      bresp;
  logic                            bvalid;
  logic                            bready;
  logic [dtePkg::axiAddrWidth-1:0] araddr;
  logic                            arvalid;
  logic                            arready;
  logic [31:0]                     rdata;
  logic [1:0]                      rresp;
  logic                            rvalid;
  logic                            rready;
  logic                            crobar;

  tGoldenLine golden[$];
  int         errorCount;
  int         checkCount;
  bit         goldenLoaded;

  dteSubsystem uut (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .crobar(crobar)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    wait (goldenLoaded);
    repeat (resetCycles + (golden.size() + 1) * lineCycles) @(posedge clk);
    $display("Watchdog expired before all golden lines were run");
    $display("Simulation failed");
    $finish;
  end

  task automatic compareReply(input dtePkg::tWord36 actual, input dtePkg::tWord36 expected,
                              input int lineNo);
    checkCount++;
    if (actual !== expected) begin
      $display("Mismatch at %0t: line %0d reply %06o,,%06o expected %06o,,%06o", $time,
               lineNo, actual.lh, actual.rh, expected.lh, expected.rh);
      errorCount++;
    end
  endtask

  task automatic compareStatus(input dtePkg::tDteStatus actual,
                               input dtePkg::tDteStatus expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s busy %b crobar %b expected busy %b crobar %b", $time,
               what, actual.busy, actual.crobar, expected.busy, expected.crobar);
      errorCount++;
    end
  endtask

  task automatic compareAprId(input dtePkg::tAprId actual, input dtePkg::tAprId expected);
    checkCount++;
    if (actual.fields !== expected.fields) begin
      $display("Mismatch at %0t: APR ID fields %o.%o(%o) %06o expected %o.%o(%o) %06o",
               $time, actual.fields.ucodeMajor, actual.fields.ucodeMinor,
               actual.fields.ucodeEdit, actual.fields.hwOptions,
               expected.fields.ucodeMajor, expected.fields.ucodeMinor,
               expected.fields.ucodeEdit, expected.fields.hwOptions);
      errorCount++;
    end
  endtask

  task automatic loadGolden(output bit ok);
    int         fd;
    int         fields;
    int         typeVal;
    int         funcVal;
    int         dataLh;
    int         dataRh;
    int         expLh;
    int         expRh;
    int         expCrobar;
    string      line;
    tGoldenLine entry;
    ok = 1'b0;
    fd = $fopen(goldenPath, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%o %o %o %o %o %o %o", typeVal, funcVal, dataLh, dataRh,
                           expLh, expRh, expCrobar);
          if (fields == 7) begin
            entry.reqType     = dtePkg::tReqType'(typeVal[2:0]);
            entry.func        = funcVal[6:0];
            entry.data.lh     = dataLh[17:0];
            entry.data.rh     = dataRh[17:0];
            entry.expReply.lh = expLh[17:0];
            entry.expReply.rh = expRh[17:0];
            entry.expCrobar   = expCrobar[0];
            golden.push_back(entry);
          end else begin
            $display("Golden file line could not be parsed: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic writeReg(input logic [dtePkg::axiAddrWidth-1:0] addr, input logic [31:0] data);
    int waited;
    bit accepted;
    awaddr   <= addr;
    awvalid  <= 1'b1;
    wdata    <= data;
    wstrb    <= 4'hF;
    wvalid   <= 1'b1;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < pollLimit) begin
      @(posedge clk);
      accepted = awready && wready;
      waited++;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!accepted) begin
      $display("Write to register 0x%02h was never accepted", addr);
      errorCount++;
    end else begin
      waited = 0;
      while (!bvalid && waited < pollLimit) begin
        @(posedge clk);
        waited++;
      end
      if (!bvalid) begin
        $display("Write response for register 0x%02h never arrived", addr);
        errorCount++;
      end else begin
        if (bresp !== 2'b00) begin
          $display("Mismatch at %0t: write response %b is not OKAY", $time, bresp);
          errorCount++;
        end
        bready <= 1'b1;                    // Response must hold until the late ready
        @(posedge clk);
        bready <= 1'b0;
      end
    end
  endtask

  task automatic readReg(input logic [dtePkg::axiAddrWidth-1:0] addr, output logic [31:0] data);
    int waited;
    bit accepted;
    araddr   <= addr;
    arvalid  <= 1'b1;
    data     = '0;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < pollLimit) begin
      @(posedge clk);
      accepted = arready;
      waited++;
    end
    arvalid <= 1'b0;
    if (!accepted) begin
      $display("Read of register 0x%02h was never accepted", addr);
      errorCount++;
    end else begin
      waited = 0;
      while (!rvalid && waited < pollLimit) begin
        @(posedge clk);
        waited++;
      end
      if (!rvalid) begin
        $display("Read data for register 0x%02h never arrived", addr);
        errorCount++;
      end else begin
        data = rdata;
        if (rresp !== 2'b00) begin
          $display("Mismatch at %0t: read response %b is not OKAY", $time, rresp);
          errorCount++;
        end
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
      end
    end
  endtask

  task automatic waitIdle(input int lineNo, output logic [31:0] statusWord);
    int polls;
    polls = 0;
    readReg(dtePkg::regStatus, statusWord);
    while (statusWord[0] && polls < pollLimit) begin
      readReg(dtePkg::regStatus, statusWord);
      polls++;
    end
    if (statusWord[0]) begin
      $display("Busy flag still set after %0d status polls on golden line %0d", polls, lineNo);
      errorCount++;
    end
  endtask

  task automatic runLine(input int lineNo, input tGoldenLine entry);
    logic [31:0]       word;
    dtePkg::tWord36    reply;
    dtePkg::tAprId     aprId;
    dtePkg::tAprId     expId;
    dtePkg::tDteStatus actual;
    dtePkg::tDteStatus expected;
    writeReg(dtePkg::regDataLh, {14'b0, entry.data.lh});
    writeReg(dtePkg::regDataRh, {14'b0, entry.data.rh});
    writeReg(dtePkg::regCmd, {21'b0, entry.reqType, 1'b0, entry.func});
    waitIdle(lineNo, word);
    expected.busy   = 1'b0;
    expected.crobar = entry.expCrobar;
    actual.busy     = word[0];
    actual.crobar   = word[1];
    compareStatus(actual, expected, "status register");
    actual.crobar = crobar;
    compareStatus(actual, expected, "crobar output");
    readReg(dtePkg::regReplyLh, word);
    reply.lh = word[17:0];
    readReg(dtePkg::regReplyRh, word);
    reply.rh = word[17:0];
    compareReply(reply, entry.expReply, lineNo);
    if (entry.reqType == dtePkg::dteMisc) begin
      aprId.raw               = reply;   // Decode through the field view
      expId.fields.ucodeMajor = dtePkg::ucodeMajorVal;
      expId.fields.ucodeMinor = dtePkg::ucodeMinorVal;
      expId.fields.ucodeEdit  = dtePkg::ucodeEditVal;
      expId.fields.hwOptions  = dtePkg::hwOptionsVal;
      compareAprId(aprId, expId);
    end
  endtask

  initial begin
    bit                ok;
    logic [31:0]       word;
    dtePkg::tDteStatus actual;
    dtePkg::tDteStatus expected;
    rst          = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    errorCount   = 0;
    checkCount   = 0;
    goldenLoaded = 1'b0;
    loadGolden(ok);
    if (!ok) begin
      $display("Could not read the golden file %s", goldenPath);
      $display("Simulation failed");
      $finish;
    end else begin
      goldenLoaded = 1'b1;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      readReg(dtePkg::regStatus, word);
      expected.busy   = 1'b0;
      expected.crobar = 1'b1;           // Crowbar up out of reset
      actual.busy     = word[0];
      actual.crobar   = word[1];
      compareStatus(actual, expected, "status after reset");
      foreach (golden[i]) begin
        runLine(i + 1, golden[i]);
      end
      $display("Golden lines: %0d, checks: %0d, errors: %0d", golden.size(), checkCount,
               errorCount);
      if (errorCount == 0) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* dv/dteGolden.txt */
# Columns, all octal: type func dataLh dataRh replyLh replyRh crobar
# Types: 0 Misc, 1 Write, 2 DiagFunc, 3 Read, 4 ReleaseData
# Crowbar and APR ID
0 02 000000 000000 021442 400021 1
3 00 000000 000000 000000 000000 1
0 01 000000 000000 021442 400021 0
0 02 000000 000000 021442 400021 0
# Load scratch, release, read it back
1 20 123456 701234 123456 701234 0
4 00 000000 000000 123456 701234 0
2 21 000000 000000 123456 701234 0
# Complement and read
2 22 000000 000000 000000 000000 0
2 21 000000 000000 654321 076543 0
3 00 000000 000000 654321 076543 0
# Strobe counter, unknown function
2 23 000000 000000 000000 000005 0
3 00 000000 000000 000000 000005 0
2 77 000000 000000 000000 000000 0
3 00 000000 000000 000000 000000 0
2 23 000000 000000 000000 000007 0
# Read while driving returns the driven word
1 20 777777 000001 777777 000001 0
3 00 000000 000000 777777 000001 0
4 00 000000 000000 777777 000001 0
2 22 000000 000000 000000 000000 0
2 21 000000 000000 000000 777776 0
# Misc ignores data and function
0 02 111111 222222 021442 400021 0
0 05 000000 000000 021442 400021 0
# Zero load, then count of twelve strobes
1 20 000000 000000 000000 000000 0
4 00 000000 000000 000000 000000 0
2 23 000000 000000 000000 000014 0
2 21 000000 000000 000000 000000 0
0 01 000000 000000 021442 400021 0

/* dteSubsystem.f */
rtl/dtePkg.sv
rtl/dteAxiRegs.sv
rtl/dte.sv
rtl/ebusDiagTarget.sv
rtl/dteSubsystem.sv
dv/dteTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f dteSubsystem.f --top-module dteTb -o dteSim
./obj_dir/dteSim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
